// ==== compile.f ====
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_csr_file.sv
verilog/rv_core_ctrl.sv
verilog/rv_core_top.sv
testbench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_alu.sv
  - verilog/rv_regfile.sv
  - verilog/rv_csr_file.sv
  - verilog/rv_core_ctrl.sv
  - verilog/rv_core_top.sv
  - target: test
    files:
      - testbench/tb_rv_core.sv

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  localparam word_t RESET_PC    = 32'h0000_0000;
  localparam word_t MTVEC_RESET = 32'h0000_0100;
  // data area and the restart point behind the trap handler
  localparam word_t DATA        = 32'h0000_0300;
  localparam word_t MAIN2       = 32'h0000_0120;

  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_SYS   = 7'b1110011;

  typedef struct packed {
    word_t addr;
    word_t inst;
  } prog_t;

  typedef struct packed {
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } store_t;

  logic    clk;
  logic    arst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    halted;

  word_t  mem [256];
  prog_t  prog_q [$];
  store_t exp_q [$];
  word_t  asm_pc;
  integer seed = 32'h8c69_735c;
  int     wait_cnt;
  int     store_idx = 0;
  int     value_errs = 0;
  int     other_errs = 0;
  int     cycle_cnt = 0;
  int     limit;

  rv_core_top #(
    .RESET_PC    (RESET_PC),
    .MTVEC_RESET (MTVEC_RESET)
  ) dut_i (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .halted (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // instruction formats
  function automatic word_t r_type(logic [2:0] f3, logic [6:0] f7, logic [4:0] rd,
                                   logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                   logic [4:0] rs1, int imm);
    word_t v;
    v = imm;
    return {v[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(logic [2:0] f3, logic [4:0] src, logic [4:0] base,
                                   int off);
    word_t v;
    v = off;
    return {v[11:5], src, base, f3, v[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                   int off);
    word_t v;
    v = off;
    return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(logic [4:0] rd, int off);
    word_t v;
    v = off;
    return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t lane_mask(logic [3:0] sel);
    word_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  task automatic emit(word_t w);
    prog_q.push_back('{addr: asm_pc, inst: w});
    asm_pc += 4;
  endtask

  task automatic expect_store(word_t adr, word_t dat, logic [3:0] sel);
    exp_q.push_back('{adr: adr, dat: dat, sel: sel});
  endtask

  // sw rs, off(x10) with the value it must write
  task automatic store_result(logic [4:0] rs, int off, word_t value);
    emit(s_type(3'b010, rs, 10, off));
    expect_store(DATA + off, value, 4'b1111);
  endtask

  // any write from this one shows a wrong control flow path
  task automatic skipped_store();
    emit(s_type(3'b010, 0, 10, 252));
  endtask

  // first branch must fall through, second must skip the bad store
  task automatic branch_pair(logic [2:0] f3, logic [4:0] a_nt, logic [4:0] b_nt,
                             logic [4:0] a_t, logic [4:0] b_t, int off);
    emit(b_type(f3, a_nt, b_nt, 8));
    emit(b_type(f3, a_t, b_t, 8));
    skipped_store();
    store_result(20, off, 32'h55);
  endtask

  task automatic build_program();
    word_t at;
    word_t resume;
    asm_pc = RESET_PC;
    emit(i_type(OPC_IMM, 3'b000, 10, 0, DATA));
    emit(i_type(OPC_IMM, 3'b000, 1, 0, 100));
    emit(i_type(OPC_IMM, 3'b000, 2, 0, -7));
    emit(i_type(OPC_IMM, 3'b000, 20, 0, 32'h55));
    // alu, x1 = 100 and x2 = -7
    emit(r_type(3'b000, 7'h20, 3, 1, 2));
    store_result(3, 0, 32'd107);
    emit(r_type(3'b100, 7'h00, 4, 1, 2));
    store_result(4, 4, 32'hffff_ff9d);
    emit(r_type(3'b110, 7'h00, 5, 1, 2));
    store_result(5, 8, 32'hffff_fffd);
    emit(r_type(3'b111, 7'h00, 6, 1, 2));
    store_result(6, 12, 32'h0000_0060);
    emit(r_type(3'b010, 7'h00, 7, 1, 2));
    store_result(7, 16, 32'd0);
    emit(r_type(3'b011, 7'h00, 8, 1, 2));
    store_result(8, 20, 32'd1);
    emit(i_type(OPC_IMM, 3'b001, 9, 1, 4));
    store_result(9, 24, 32'h0000_0640);
    emit(i_type(OPC_IMM, 3'b101, 11, 2, 32'h401));
    store_result(11, 28, 32'hffff_fffc);
    emit(i_type(OPC_IMM, 3'b101, 12, 2, 28));
    store_result(12, 32, 32'h0000_000f);
    emit(u_type(OPC_LUI, 13, 20'h12345));
    store_result(13, 36, 32'h1234_5000);
    at = asm_pc;
    emit(u_type(OPC_AUIPC, 14, 20'h00001));
    store_result(14, 40, at + 32'h1000);
    emit(i_type(OPC_IMM, 3'b000, 15, 1, -200));
    store_result(15, 44, 32'hffff_ff9c);
    // beq, bne, blt, bge, bltu, bgeu
    branch_pair(3'b000, 1, 2, 1, 1, 48);
    branch_pair(3'b001, 1, 1, 1, 2, 52);
    branch_pair(3'b100, 1, 2, 2, 1, 56);
    branch_pair(3'b101, 2, 1, 1, 2, 60);
    branch_pair(3'b110, 2, 1, 1, 2, 64);
    branch_pair(3'b111, 1, 2, 2, 1, 68);
    // hop over the trap handler
    emit(j_type(0, MAIN2 - asm_pc));
    asm_pc = MAIN2;
    at = asm_pc;
    emit(j_type(1, 8));
    skipped_store();
    store_result(1, 72, at + 4);
    // odd jalr offset, bit 0 is dropped
    at = asm_pc;
    emit(u_type(OPC_AUIPC, 5, 20'h0));
    emit(i_type(OPC_JALR, 3'b000, 6, 5, 17));
    skipped_store();
    skipped_store();
    store_result(6, 76, at + 8);
    // sub-word stores and loads around 0x89abcdef
    emit(u_type(OPC_LUI, 16, 20'h89abd));
    emit(i_type(OPC_IMM, 3'b000, 16, 16, -529));
    store_result(16, 80, 32'h89ab_cdef);
    emit(s_type(3'b000, 16, 10, 85));
    expect_store(DATA + 84, 32'h0000_ef00, 4'b0010);
    emit(s_type(3'b001, 16, 10, 90));
    expect_store(DATA + 88, 32'hcdef_0000, 4'b1100);
    emit(i_type(OPC_LOAD, 3'b000, 17, 10, 81));
    store_result(17, 92, 32'hffff_ffcd);
    emit(i_type(OPC_LOAD, 3'b100, 18, 10, 83));
    store_result(18, 96, 32'h0000_0089);
    emit(i_type(OPC_LOAD, 3'b001, 19, 10, 82));
    store_result(19, 100, 32'hffff_89ab);
    emit(i_type(OPC_LOAD, 3'b101, 21, 10, 80));
    store_result(21, 104, 32'h0000_cdef);
    emit(i_type(OPC_LOAD, 3'b100, 24, 10, 85));
    store_result(24, 108, 32'h0000_00ef);
    emit(i_type(OPC_LOAD, 3'b001, 25, 10, 90));
    store_result(25, 112, 32'hffff_cdef);
    // mtvec: write 0xf0, set 0x30f, clear 0x2f0
    emit(i_type(OPC_IMM, 3'b000, 27, 0, 32'h0f0));
    emit(i_type(OPC_SYS, 3'b001, 26, 27, 12'h305));
    emit(i_type(OPC_IMM, 3'b000, 29, 0, 32'h30f));
    emit(i_type(OPC_SYS, 3'b010, 28, 29, 12'h305));
    emit(i_type(OPC_IMM, 3'b000, 31, 0, 32'h2f0));
    emit(i_type(OPC_SYS, 3'b011, 30, 31, 12'h305));
    emit(i_type(OPC_SYS, 3'b010, 9, 0, 12'h305));
    store_result(26, 116, MTVEC_RESET);
    store_result(28, 120, 32'h0000_00f0);
    store_result(30, 124, 32'h0000_03ff);
    store_result(9, 128, 32'h0000_010f);
    emit(i_type(OPC_IMM, 3'b000, 27, 0, MTVEC_RESET));
    emit(i_type(OPC_SYS, 3'b001, 0, 27, 12'h305));
    // ecall, handler stores mepc and mcause, then returns past the ecall
    at = asm_pc;
    emit(32'h0000_0073);
    resume = asm_pc;
    asm_pc = MTVEC_RESET;
    emit(i_type(OPC_SYS, 3'b010, 1, 0, 12'h341));
    store_result(1, 132, at);
    emit(i_type(OPC_SYS, 3'b010, 2, 0, 12'h342));
    store_result(2, 136, 32'd11);
    emit(i_type(OPC_IMM, 3'b000, 1, 1, 4));
    emit(i_type(OPC_SYS, 3'b001, 0, 1, 12'h341));
    emit(32'h3020_0073);
    asm_pc = resume;
    store_result(20, 140, 32'h55);
    emit(32'h0010_0073);
  endtask

  task automatic check_store(wb_req_t req);
    store_t e;
    assert (store_idx < exp_q.size())
      else begin
        other_errs++;
        $display("unexpected extra store to address %h at time %0t", req.adr, $time);
      end
    if (store_idx < exp_q.size()) begin
      e = exp_q[store_idx];
      assert (req.adr == e.adr && req.sel == e.sel && (req.dat & lane_mask(req.sel)) == e.dat)
        else begin
          value_errs++;
          $display("FAILED %0t: store %0d got adr %h dat %h sel %b, expected adr %h dat %h sel %b",
                   $time, store_idx, req.adr, req.dat & lane_mask(req.sel), req.sel,
                   e.adr, e.dat, e.sel);
        end
    end
    store_idx++;
  endtask

  // wishbone memory, one-cycle ack after a random wait
  always @(posedge clk) begin
    if (!arst_n) begin
      wb_rsp   <= '0;
      wait_cnt <= {$random(seed)} % 4;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;
      wait_cnt   <= {$random(seed)} % 4;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        wb_rsp.ack <= 1'b1;
        wb_rsp.dat <= mem[wb_req.adr[9:2]];
        if (wb_req.we) begin
          for (int b = 0; b < 4; b++) begin
            if (wb_req.sel[b]) begin
              mem[wb_req.adr[9:2]][8*b +: 8] <= wb_req.dat[8*b +: 8];
            end
          end
          check_store(wb_req);
        end
      end
    end
  end

  initial begin
    arst_n = 1'b0;
    wb_rsp = '0;
    build_program();
    limit = 40 * prog_q.size();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hdead_0000 | (i << 2);
    end
    for (int k = 0; k < prog_q.size(); k++) begin
      mem[prog_q[k].addr[9:2]] = prog_q[k].inst;
    end

    @(posedge clk);
    @(negedge clk);
    assert (!wb_req.cyc && !halted)
      else begin
        other_errs++;
        $display("bus cycle or halted seen while reset is asserted");
      end
    @(posedge clk);
    arst_n <= 1'b1;

    while (!halted && cycle_cnt < limit) begin
      @(negedge clk);
    end
    assert (halted)
      else begin
        other_errs++;
        $display("timeout: core did not halt within %0d cycles", limit);
      end

    if (halted) begin
      // bus must stay quiet once halted
      repeat (20) begin
        @(negedge clk);
        assert (!wb_req.cyc && halted)
          else begin
            other_errs++;
            $display("bus cycle started or halted dropped after ebreak at %0t", $time);
          end
      end
      assert (store_idx >= exp_q.size())
        else begin
          other_errs++;
          $display("missing stores: only %0d of %0d seen", store_idx, exp_q.size());
        end
    end

    $display("stores seen: %0d of %0d, value errors: %0d, other errors: %0d",
             store_idx, exp_q.size(), value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
  parameter word_t RESET_PC    = 32'h0000_0000,
  parameter word_t MTVEC_RESET = 32'h0000_0100
) (
  input  logic    clk,
  input  logic    arst_n,
  output wb_req_t wb_req,
  input  wb_rsp_t wb_rsp,
  output logic    halted
);

  word_t     inst, rs1_data, rs2_data, alu_a, alu_b, alu_result;
  word_t     csr_rdata, trap_target, ret_target, rf_wdata, pc;
  logic      inst_valid, rf_wen, csr_wen, csr_trap;
  reg_addr_t rf_waddr;
  decode_t   dec;

  rv_decoder u_decoder (
    .inst       (inst),
    .inst_valid (inst_valid),
    .dec        (dec)
  );

  rv_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (dec.alu_op),
    .result (alu_result)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .wen    (rf_wen)
  );

  rv_csr_file #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_csr_file (
    .clk         (clk),
    .arst_n      (arst_n),
    .addr        (dec.csr_addr),
    .rdata       (csr_rdata),
    .wen         (csr_wen),
    .wdata       (alu_result),
    .trap        (csr_trap),
    .trap_pc     (pc),
    .trap_target (trap_target),
    .ret_target  (ret_target)
  );

  rv_core_ctrl #(
    .RESET_PC (RESET_PC)
  ) u_core_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .dec         (dec),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alu_result  (alu_result),
    .csr_rdata   (csr_rdata),
    .trap_target (trap_target),
    .ret_target  (ret_target),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .rf_wen      (rf_wen),
    .csr_wen     (csr_wen),
    .csr_trap    (csr_trap),
    .pc          (pc),
    .halted      (halted)
  );

endmodule

// ==== verilog/rv_core_ctrl.sv ====
`timescale 1ns/1ps

module rv_core_ctrl import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic      clk,
  input  logic      arst_n,
  output wb_req_t   wb_req,
  input  wb_rsp_t   wb_rsp,
  output word_t     inst,
  output logic      inst_valid,
  input  decode_t   dec,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  word_t     alu_result,
  input  word_t     csr_rdata,
  input  word_t     trap_target,
  input  word_t     ret_target,
  output word_t     alu_a,
  output word_t     alu_b,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata,
  output logic      rf_wen,
  output logic      csr_wen,
  output logic      csr_trap,
  output word_t     pc,
  output logic      halted
);

  typedef enum logic [2:0] {FETCH, EXEC, MEM, WB, HALT} state_e;

  state_e     state;
  logic       bus_en;
  word_t      inst_q, alu_q, csr_q, ld_q;
  decode_t    dec_q;
  logic       taken, taken_q, ack;
  word_t      pc_plus4, npc, ld_shift, ld_ext, st_dat;
  logic [3:0] st_sel;

  assign ack        = wb_rsp.ack & wb_req.cyc;
  assign inst       = inst_q;
  assign inst_valid = (state == EXEC);
  assign halted     = (state == HALT);
  assign pc_plus4   = pc + 32'd4;

  // operands follow the live decode of the held instruction
  assign alu_a = dec.use_pc ? pc : rs1_data;
  always_comb begin
    unique case (dec.op2_sel)
      OP2_IMM: alu_b = dec.imm;
      OP2_CSR: alu_b = csr_rdata;
      default: alu_b = rs2_data;
    endcase
  end

  // funct3[0] turns beq, blt and bltu into their inverted forms
  assign taken = ((dec.alu_op == ALU_SUB) ? (alu_result == '0) : alu_result[0]) ^ inst_q[12];

  always_comb begin
    unique case (dec_q.npc_sel)
      NPC_JAL:    npc = alu_q;
      NPC_JALR:   npc = {alu_q[31:1], 1'b0};
      NPC_BRANCH: npc = taken_q ? pc + dec_q.imm : pc_plus4;
      NPC_TRAP:   npc = trap_target;
      NPC_RET:    npc = ret_target;
      default:    npc = pc_plus4;
    endcase
  end

  // store lanes
  always_comb begin
    unique case (dec_q.mem_size)
      MEM_B: begin
        st_dat = {4{rs2_data[7:0]}};
        st_sel = 4'b0001 << alu_q[1:0];
      end
      MEM_H: begin
        st_dat = {2{rs2_data[15:0]}};
        st_sel = alu_q[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_dat = rs2_data;
        st_sel = 4'b1111;
      end
    endcase
  end

  // load lane extraction and extension
  assign ld_shift = wb_rsp.dat >> {alu_q[1:0], 3'b000};
  always_comb begin
    unique case (dec_q.mem_size)
      MEM_B:   ld_ext = {{24{dec_q.load_signed & ld_shift[7]}}, ld_shift[7:0]};
      MEM_H:   ld_ext = {{16{dec_q.load_signed & ld_shift[15]}}, ld_shift[15:0]};
      default: ld_ext = ld_shift;
    endcase
  end

  always_comb begin
    wb_req = '0;
    if (state == FETCH && bus_en) begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.adr = pc;
      wb_req.sel = 4'b1111;
    end else if (state == MEM) begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = dec_q.mem_wen;
      wb_req.adr = {alu_q[31:2], 2'b00};
      wb_req.dat = st_dat;
      wb_req.sel = st_sel;
    end
  end

  always_comb begin
    unique case (dec_q.wdata_sel)
      WB_PC4:  rf_wdata = pc_plus4;
      WB_LOAD: rf_wdata = ld_q;
      WB_CSR:  rf_wdata = csr_q;
      default: rf_wdata = alu_q;
    endcase
  end

  assign rf_waddr = dec_q.rd;
  assign rf_wen   = (state == WB) & dec_q.reg_wen;
  assign csr_wen  = (state == WB) & dec_q.csr_wen;
  assign csr_trap = (state == WB) & dec_q.trap;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= FETCH;
      pc     <= RESET_PC;
      bus_en <= 1'b0;
    end else begin
      bus_en <= 1'b1;
      unique case (state)
        FETCH: if (ack) state <= EXEC;
        EXEC: begin
          if (dec.halt) state <= HALT;
          else if (dec.mem_ren || dec.mem_wen) state <= MEM;
          else state <= WB;
        end
        MEM: if (ack) state <= WB;
        WB: begin
          pc    <= npc;
          state <= FETCH;
        end
        default: state <= HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH && ack) begin
      inst_q <= wb_rsp.dat;
    end
    if (state == EXEC) begin
      dec_q   <= dec;
      alu_q   <= alu_result;
      taken_q <= taken;
      csr_q   <= csr_rdata;
    end
    if (state == MEM && ack) begin
      ld_q <= ld_ext;
    end
  end

  // cyc drops in the cycle after ack
  assert property (@(posedge clk) disable iff (!arst_n)
    (wb_req.stb && wb_rsp.ack) |=> !wb_req.cyc)
    else $error("wishbone cycle not closed after ack");

  // request held until the slave acknowledges
  assert property (@(posedge clk) disable iff (!arst_n)
    (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req))
    else $error("wishbone request changed before ack");

endmodule

// ==== verilog/rv_csr_file.sv ====
`timescale 1ns/1ps

module rv_csr_file import rv_pkg::*; #(
  parameter word_t MTVEC_RESET = 32'h0000_0100
) (
  input  logic      clk,
  input  logic      arst_n,
  input  csr_addr_t addr,
  output word_t     rdata,
  input  logic      wen,
  input  word_t     wdata,
  input  logic      trap,
  input  word_t     trap_pc,
  output word_t     trap_target,
  output word_t     ret_target
);

  word_t mtvec, mepc, mcause;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec  <= MTVEC_RESET;
      mepc   <= '0;
      mcause <= '0;
    end else if (trap) begin
      mepc   <= trap_pc;
      mcause <= CAUSE_ECALL_M;
    end else if (wen) begin
      unique case (addr)
        CSR_MTVEC:  mtvec  <= wdata;
        CSR_MEPC:   mepc   <= wdata;
        CSR_MCAUSE: mcause <= wdata;
        default: ;
      endcase
    end
  end

  // unknown addresses read as zero
  always_comb begin
    unique case (addr)
      CSR_MTVEC:  rdata = mtvec;
      CSR_MEPC:   rdata = mepc;
      CSR_MCAUSE: rdata = mcause;
      default:    rdata = '0;
    endcase
  end

  assign trap_target = mtvec;
  assign ret_target  = mepc;

  // ecall and csr writes come from different instructions
  assert property (@(posedge clk) disable iff (!arst_n) !(wen && trap))
    else $error("csr write and trap in the same cycle");

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  logic      wen
);

  word_t regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    unique case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'b0, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      // csrrs: rs1 bits set in the old csr value
      ALU_SET:    result = a | b;
      // csrrc: rs1 bits cleared from the old csr value on b
      ALU_CLR:    result = b & ~a;
      default:    result = '0;
    endcase
  end

endmodule

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  word_t   inst,
  input  logic    inst_valid,
  output decode_t dec
);

  localparam logic [6:0] OPC_LUI    = 7'b01_101_11;
  localparam logic [6:0] OPC_AUIPC  = 7'b00_101_11;
  localparam logic [6:0] OPC_JAL    = 7'b11_011_11;
  localparam logic [6:0] OPC_JALR   = 7'b11_001_11;
  localparam logic [6:0] OPC_BRANCH = 7'b11_000_11;
  localparam logic [6:0] OPC_LOAD   = 7'b00_000_11;
  localparam logic [6:0] OPC_STORE  = 7'b01_000_11;
  localparam logic [6:0] OPC_OP_IMM = 7'b00_100_11;
  localparam logic [6:0] OPC_OP     = 7'b01_100_11;
  localparam logic [6:0] OPC_SYSTEM = 7'b11_100_11;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // alt selects sub / arithmetic shift
  function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
    alu_op_e op;
    unique case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    decode_t d;
    d          = '0;
    d.rs1      = inst[19:15];
    d.rs2      = inst[24:20];
    d.rd       = inst[11:7];
    d.alu_op   = ALU_PASS_B;
    d.op2_sel  = OP2_REG;
    d.npc_sel  = NPC_SEQ;
    d.wdata_sel = WB_ALU;
    d.mem_size = (funct3[1:0] == 2'b00) ? MEM_B : (funct3[1:0] == 2'b01) ? MEM_H : MEM_W;
    d.csr_addr = inst[31:20];

    unique case (opcode)
      OPC_LUI: begin
        // x0 + imm
        d.rs1     = '0;
        d.imm     = imm_u;
        d.op2_sel = OP2_IMM;
        d.alu_op  = ALU_ADD;
        d.reg_wen = 1'b1;
      end
      OPC_AUIPC: begin
        d.imm     = imm_u;
        d.op2_sel = OP2_IMM;
        d.use_pc  = 1'b1;
        d.alu_op  = ALU_ADD;
        d.reg_wen = 1'b1;
      end
      OPC_JAL: begin
        d.imm       = imm_j;
        d.op2_sel   = OP2_IMM;
        d.use_pc    = 1'b1;
        d.alu_op    = ALU_ADD;
        d.npc_sel   = NPC_JAL;
        d.wdata_sel = WB_PC4;
        d.reg_wen   = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          d.imm       = imm_i;
          d.op2_sel   = OP2_IMM;
          d.alu_op    = ALU_ADD;
          d.npc_sel   = NPC_JALR;
          d.wdata_sel = WB_PC4;
          d.reg_wen   = 1'b1;
        end
      end
      OPC_BRANCH: begin
        // compare on sub, slt or sltu; funct3[0] inverts in the controller
        d.imm = imm_b;
        if (funct3[2:1] != 2'b01) begin
          d.npc_sel = NPC_BRANCH;
          d.alu_op  = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
        end
      end
      OPC_LOAD: begin
        d.imm         = imm_i;
        d.op2_sel     = OP2_IMM;
        d.alu_op      = ALU_ADD;
        d.load_signed = ~funct3[2];
        d.mem_ren     = 1'b1;
        d.wdata_sel   = WB_LOAD;
        d.reg_wen     = 1'b1;
      end
      OPC_STORE: begin
        d.imm     = imm_s;
        d.op2_sel = OP2_IMM;
        d.alu_op  = ALU_ADD;
        d.mem_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        d.imm     = imm_i;
        d.op2_sel = OP2_IMM;
        d.alu_op  = alu_from_funct3(funct3, funct3 == 3'b101 && inst[30]);
        d.reg_wen = 1'b1;
      end
      OPC_OP: begin
        // RV32M encodings fall through as no-ops
        if (funct7 == 7'b000_0000 || funct7 == 7'b010_0000) begin
          d.alu_op  = alu_from_funct3(funct3, inst[30]);
          d.reg_wen = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        unique case (funct3)
          3'b000: begin
            if (inst == 32'h0000_0073) begin
              d.trap     = 1'b1;
              d.npc_sel  = NPC_TRAP;
              d.csr_addr = CSR_MTVEC;
            end else if (inst == 32'h3020_0073) begin
              d.mret     = 1'b1;
              d.npc_sel  = NPC_RET;
              d.csr_addr = CSR_MEPC;
            end else if (inst == 32'h0010_0073) begin
              d.halt = 1'b1;
            end
          end
          3'b001: begin
            // rs1 + x0 gives the new value
            d.rs2     = '0;
            d.alu_op  = ALU_ADD;
            d.csr_wen = 1'b1;
          end
          3'b010: begin
            d.op2_sel = OP2_CSR;
            d.alu_op  = ALU_SET;
            d.csr_wen = 1'b1;
          end
          3'b011: begin
            d.op2_sel = OP2_CSR;
            d.alu_op  = ALU_CLR;
            d.csr_wen = 1'b1;
          end
          default: ;
        endcase
        if (funct3[2:1] == 2'b01 || funct3 == 3'b001) begin
          d.wdata_sel = WB_CSR;
          d.reg_wen   = 1'b1;
        end
      end
      default: ;
    endcase

    d.reg_wen = d.reg_wen & inst_valid;
    d.mem_ren = d.mem_ren & inst_valid;
    d.mem_wen = d.mem_wen & inst_valid;
    d.csr_wen = d.csr_wen & inst_valid;
    d.trap    = d.trap & inst_valid;
    dec       = d;
  end

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
    ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B, ALU_SET, ALU_CLR
  } alu_op_e;

  typedef enum logic [2:0] {
    NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH, NPC_TRAP, NPC_RET
  } npc_sel_e;

  typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_CSR} op2_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_LOAD, WB_CSR} wdata_sel_e;

  typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W} mem_size_e;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_e    alu_op;
    op2_sel_e   op2_sel;
    logic       use_pc;
    npc_sel_e   npc_sel;
    wdata_sel_e wdata_sel;
    mem_size_e  mem_size;
    logic       load_signed;
    logic       reg_wen;
    logic       mem_ren;
    logic       mem_wen;
    csr_addr_t  csr_addr;
    logic       csr_wen;
    logic       trap;
    logic       mret;
    logic       halt;
  } decode_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // machine CSR addresses
  localparam csr_addr_t CSR_MTVEC  = 12'h305;
  localparam csr_addr_t CSR_MEPC   = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'd11;

endpackage
